// File: src.f
+incdir+include
logic/fc_pkg.sv
logic/fc_seq_if.sv
logic/fc_buf.sv
logic/fc_mac.sv
logic/fc_step_cnt.sv
logic/fc_ctrl.sv
logic/fc_top.sv
tb/tb_fc_top.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_fc_top
RTL_TOP    := fc_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/tb_fc_tasks.svh
`ifndef TB_FC_TASKS_SVH
`define TB_FC_TASKS_SVH

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    $display("TB FAILED");
    $fatal(1, "mismatch on %s", name);
  end
endtask

// push every queued word through the input stream, with random gaps
task automatic send_words(input int gap_pct);
  int idx;
  idx = 0;
  while (idx < beats.size()) begin
    check_val("s_ready", 32'(s_ready), 32'd1);  // load still open
    if (roll_below(gap_pct)) begin
      s_valid = 1'b0;
      s_data  = $random(seed);
    end else begin
      s_valid = 1'b1;
      s_data  = beats[idx];
    end
    @(posedge clk);
    #1;
    if (s_valid) idx++;
  end
  s_valid = 1'b0;
  check_val("s_ready", 32'(s_ready), 32'd0);
endtask

// four results in neuron order, m_ready randomly held low
task automatic recv_results(input int n, input int stall_pct);
  int          k;
  int          wait_cyc;
  bit          seen;
  bit          held;
  logic [31:0] hold_data;
  logic        hold_last;
  k         = 0;
  wait_cyc  = 0;
  seen      = 1'b0;
  held      = 1'b0;
  hold_data = '0;
  hold_last = 1'b0;
  while (k < fc_pkg::LANES) begin
    check_val("done", 32'(done), 32'd0);
    if (held) begin  // stalled beat must not move
      check_val("m_valid", 32'(m_valid), 32'd1);
      check_val("m_data", m_data, hold_data);
      check_val("m_last", 32'(m_last), 32'(hold_last));
    end
    if (m_valid && !seen) begin
      seen = 1'b1;
      check_val("result latency", 32'(wait_cyc), 32'(1 + 4 * n + fc_pkg::MAC_LAT));
    end
    m_ready = !roll_below(stall_pct);
    held    = 1'b0;
    if (m_valid && m_ready) begin
      check_val("m_data", m_data, expect_q[k]);
      check_val("m_last", 32'(m_last), 32'(k == fc_pkg::LANES - 1));
      k++;
    end else if (m_valid) begin
      held      = 1'b1;
      hold_data = m_data;
      hold_last = m_last;
    end
    @(posedge clk);
    #1;
    wait_cyc++;
  end
  m_ready = 1'b0;
  check_val("done", 32'(done), 32'd1);
  @(posedge clk);
  #1;
  check_val("done", 32'(done), 32'd0);  // single cycle pulse
endtask

// signed dot product of neuron k, wrapped to the accumulator width
function automatic logic [31:0] dot_ref(input int k, input int n);
  int                       sum;
  int                       w;
  int                       b;
  logic [fc_pkg::ACC_W-1:0] acc_w;
  sum = 0;
  for (w = 0; w < n; w++) begin
    for (b = 0; b < fc_pkg::LANES; b++) begin
      sum += $signed(feat_mem[w][8*b +: 8]) * $signed(wgt_mem[k][w][8*b +: 8]);
    end
  end
  acc_w = sum[fc_pkg::ACC_W-1:0];
  return {{(32 - fc_pkg::ACC_W){acc_w[fc_pkg::ACC_W-1]}}, acc_w};
endfunction

`endif

// File: tb/tb_fc_top.sv
`timescale 1ns/1ps

module tb_fc_top;

  localparam int FEAT_WORDS_MAX = 64;
  localparam int LW             = $clog2(FEAT_WORDS_MAX + 1);
  localparam int LANES          = fc_pkg::LANES;

  // value modes for features and weights
  localparam int MODE_RAND = 0;
  localparam int MODE_NEG  = 1;  // every byte -128
  localparam int MODE_POS  = 2;  // every byte +127
  localparam int MODE_MIX  = 3;  // each byte -128 or +127

  typedef struct packed {
    int words;
    int mode;
    int gap_pct;    // chance of an idle input cycle
    int stall_pct;  // chance of m_ready low
    int reload;     // new feature vector first
  } case_t;

  localparam int NUM_CASES = 8;
  localparam case_t CASES [NUM_CASES] = '{
    '{1,  MODE_RAND, 0,  0,  1},
    '{4,  MODE_RAND, 30, 30, 1},
    '{4,  MODE_RAND, 20, 50, 0},  // same features as the row above
    '{64, MODE_RAND, 25, 25, 1},
    '{64, MODE_NEG,  0,  0,  1},  // largest accumulator value
    '{16, MODE_POS,  10, 40, 1},
    '{8,  MODE_MIX,  40, 60, 1},
    '{8,  MODE_MIX,  0,  30, 0}
  };

  logic          clk;
  logic          rstn;
  logic          s_valid;
  logic          s_ready;
  logic [31:0]   s_data;
  logic          m_valid;
  logic          m_ready;
  logic [31:0]   m_data;
  logic          m_last;
  logic          cmd_load_feat;
  logic          cmd_load_wgt;
  logic [LW-1:0] feat_words;
  logic          done;

  integer      seed;
  int          cycle_cnt = 0;
  int          cycle_limit;
  logic [31:0] feat_mem [FEAT_WORDS_MAX];
  logic [31:0] wgt_mem [LANES][FEAT_WORDS_MAX];
  logic [31:0] beats [$];       // words for the next load
  logic [31:0] expect_q [LANES];

  fc_top #(.FEAT_WORDS_MAX(FEAT_WORDS_MAX)) u_dut (
    .clk           (clk),
    .rstn          (rstn),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .s_data        (s_data),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .m_data        (m_data),
    .m_last        (m_last),
    .cmd_load_feat (cmd_load_feat),
    .cmd_load_wgt  (cmd_load_wgt),
    .feat_words    (feat_words),
    .done          (done)
  );

  `include "tb_fc_tasks.svh"

  always #50 clk = ~clk;

  // true with a chance of pct percent
  function automatic bit roll_below(input int pct);
    int r;
    r = $unsigned($random(seed)) % 100;
    return r < pct;
  endfunction

  function automatic logic [31:0] gen_word(input int mode);
    logic [31:0] w;
    logic [31:0] pick;
    int          b;
    w    = $random(seed);
    pick = $random(seed);
    case (mode)
      MODE_NEG: w = 32'h8080_8080;
      MODE_POS: w = 32'h7f7f_7f7f;
      MODE_MIX: begin
        for (b = 0; b < LANES; b++) w[8*b +: 8] = pick[b] ? 8'h80 : 8'h7f;
      end
      default: w = w;
    endcase
    return w;
  endfunction

  ////////////////////////////////////////
  // run limit
  ////////////////////////////////////////
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the engine did not finish within %0d cycles", cycle_cnt);
      $display("TB FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  initial begin
    int r;
    int n;
    int k;
    int w;
    seed          = 32'h48e7_ce37;
    clk           = 1'b0;
    rstn          = 1'b0;
    s_valid       = 1'b0;
    s_data        = '0;
    m_ready       = 1'b0;
    cmd_load_feat = 1'b0;
    cmd_load_wgt  = 1'b0;
    feat_words    = LW'(1);
    cycle_limit   = 20;  // reset and settle
    for (r = 0; r < NUM_CASES; r++) cycle_limit += 30 * CASES[r].words + 200;

    // outputs quiet during reset and right after it
    repeat (16) begin
      @(posedge clk);
      #1;
      check_val("s_ready", 32'(s_ready), 32'd0);
      check_val("m_valid", 32'(m_valid), 32'd0);
      check_val("done", 32'(done), 32'd0);
    end
    rstn = 1'b1;
    @(posedge clk);
    #1;
    check_val("s_ready", 32'(s_ready), 32'd0);
    check_val("m_valid", 32'(m_valid), 32'd0);
    check_val("done", 32'(done), 32'd0);

    ////////////////////////////////////////
    // apply the case table
    ////////////////////////////////////////
    for (r = 0; r < NUM_CASES; r++) begin
      n          = CASES[r].words;
      feat_words = LW'(n);
      if (CASES[r].reload != 0) begin
        beats.delete();
        for (w = 0; w < n; w++) begin
          feat_mem[w] = gen_word(CASES[r].mode);
          beats.push_back(feat_mem[w]);
        end
        cmd_load_feat = 1'b1;
        @(posedge clk);
        #1;
        cmd_load_feat = 1'b0;
        send_words(CASES[r].gap_pct);
      end
      beats.delete();
      for (k = 0; k < LANES; k++) begin
        for (w = 0; w < n; w++) begin  // one row per neuron
          wgt_mem[k][w] = gen_word(CASES[r].mode);
          beats.push_back(wgt_mem[k][w]);
        end
      end
      cmd_load_wgt = 1'b1;
      @(posedge clk);
      #1;
      cmd_load_wgt = 1'b0;
      send_words(CASES[r].gap_pct);
      for (k = 0; k < LANES; k++) expect_q[k] = dot_ref(k, n);
      recv_results(n, CASES[r].stall_pct);
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: logic/fc_top.sv
`timescale 1ns/1ps

module fc_top #(
  parameter int FEAT_WORDS_MAX = 64
) (
  input  logic                                clk,
  input  logic                                rstn,
  // input stream
  input  logic                                s_valid,
  output logic                                s_ready,
  input  logic [fc_pkg::DATA_W-1:0]           s_data,
  // output stream
  output logic                                m_valid,
  input  logic                                m_ready,
  output logic [fc_pkg::DATA_W-1:0]           m_data,
  output logic                                m_last,
  // commands
  input  logic                                cmd_load_feat,
  input  logic                                cmd_load_wgt,
  input  logic [$clog2(FEAT_WORDS_MAX+1)-1:0] feat_words,
  output logic                                done
);

  fc_seq_if #(.FEAT_WORDS_MAX(FEAT_WORDS_MAX)) seq ();

  logic                                         feat_we;
  logic [fc_pkg::LANES-1:0]                     wgt_we;
  logic                                         mac_valid;
  logic                                         mac_first;
  logic [fc_pkg::LANES-1:0][fc_pkg::ACC_W-1:0] acc;
  fc_pkg::fc_word_u                             s_word;
  fc_pkg::fc_word_u                             feat_rd;
  fc_pkg::fc_word_u                             wgt_rd [fc_pkg::LANES];

  assign s_word.raw = s_data;

  fc_ctrl u_ctrl (
    .clk           (clk),
    .rstn          (rstn),
    .seq           (seq),
    .cmd_load_feat (cmd_load_feat),
    .cmd_load_wgt  (cmd_load_wgt),
    .s_valid       (s_valid),
    .s_ready       (s_ready),
    .feat_we       (feat_we),
    .wgt_we        (wgt_we),
    .mac_valid     (mac_valid),
    .mac_first     (mac_first),
    .acc           (acc),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .m_data        (m_data),
    .m_last        (m_last),
    .done          (done)
  );

  fc_step_cnt #(.FEAT_WORDS_MAX(FEAT_WORDS_MAX)) u_cnt (
    .clk           (clk),
    .rstn          (rstn),
    .seq           (seq),
    .cmd_load_feat (cmd_load_feat),
    .feat_words    (feat_words)
  );

  // feature vector, shared by every lane
  fc_buf #(.DEPTH(FEAT_WORDS_MAX)) u_feat (
    .clk   (clk),
    .we    (feat_we),
    .addr  (seq.word_idx),
    .wdata (s_word),
    .rdata (feat_rd)
  );

  ////////////////////////////////////////
  // one weight bank and lane per neuron
  ////////////////////////////////////////
  for (genvar k = 0; k < fc_pkg::LANES; k++) begin : g_lane
    fc_buf #(.DEPTH(FEAT_WORDS_MAX)) u_wgt (
      .clk   (clk),
      .we    (wgt_we[k]),
      .addr  (seq.word_idx),
      .wdata (s_word),
      .rdata (wgt_rd[k])
    );

    fc_mac u_mac (
      .clk      (clk),
      .rstn     (rstn),
      .valid    (mac_valid),
      .first    (mac_first),
      .byte_sel (seq.byte_idx),
      .feat     (feat_rd),
      .wgt      (wgt_rd[k]),
      .acc      (acc[k])
    );
  end

endmodule

// File: logic/fc_ctrl.sv
`timescale 1ns/1ps

module fc_ctrl (
  input  logic                                         clk,
  input  logic                                         rstn,
  fc_seq_if.ctrl                                       seq,
  input  logic                                         cmd_load_feat,
  input  logic                                         cmd_load_wgt,
  input  logic                                         s_valid,
  output logic                                         s_ready,
  output logic                                         feat_we,
  output logic [fc_pkg::LANES-1:0]                     wgt_we,
  output logic                                         mac_valid,
  output logic                                         mac_first,
  input  logic [fc_pkg::LANES-1:0][fc_pkg::ACC_W-1:0] acc,
  output logic                                         m_valid,
  input  logic                                         m_ready,
  output logic [fc_pkg::DATA_W-1:0]                    m_data,
  output logic                                         m_last,
  output logic                                         done
);

  localparam int DATA_W  = fc_pkg::DATA_W;
  localparam int ACC_W   = fc_pkg::ACC_W;
  localparam int DRAIN_W = $clog2(fc_pkg::MAC_LAT + 1);

  localparam logic [2:0] st_idle      = 3'd0;
  localparam logic [2:0] st_load_feat = 3'd1;
  localparam logic [2:0] st_load_wgt  = 3'd2;
  localparam logic [2:0] st_compute   = 3'd3;
  localparam logic [2:0] st_drain     = 3'd4;
  localparam logic [2:0] st_send      = 3'd5;

  logic [2:0]         state;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               accept;
  logic               xfer;

  assign accept = s_ready & s_valid;
  assign xfer   = m_valid & m_ready;

  ////////////////////////////////////////
  // decode from state
  ////////////////////////////////////////
  always_comb begin
    s_ready   = (state == st_load_feat) || (state == st_load_wgt);
    feat_we   = (state == st_load_feat) && s_valid;
    mac_valid = (state == st_compute);
    mac_first = mac_valid && (seq.byte_idx == '0) && (seq.word_idx == '0);
    seq.clear = (state == st_idle) || (state == st_drain);  // counters parked at zero
    for (int k = 0; k < fc_pkg::LANES; k++) begin
      wgt_we[k] = (state == st_load_wgt) && s_valid && (seq.bank_idx == k);
    end
  end

  always_comb begin
    seq.mode = fc_pkg::load_feat;
    seq.step = 1'b0;
    case (state)
      st_load_feat: begin
        seq.step = accept;
      end
      st_load_wgt: begin
        seq.mode = fc_pkg::load_wgt;
        seq.step = accept;
      end
      st_compute: begin
        seq.mode = fc_pkg::compute;
        seq.step = 1'b1;  // one sample per cycle
      end
      st_drain: begin
        seq.mode = fc_pkg::compute;
      end
      st_send: begin
        seq.mode = fc_pkg::send;
        seq.step = xfer;
      end
      default: begin
        seq.step = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // FSM and output handshake
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= st_idle;
      drain_cnt <= '0;
      m_valid   <= 1'b0;
      m_last    <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_load_feat) state <= st_load_feat;
          else if (cmd_load_wgt) state <= st_load_wgt;
        end
        st_load_feat: begin
          if (accept && seq.word_last) state <= st_idle;
        end
        st_load_wgt: begin
          if (accept && seq.bank_last) state <= st_compute;  // last beat of bank 3
        end
        st_compute: begin
          if (seq.word_last) begin
            state     <= st_drain;
            drain_cnt <= DRAIN_W'(fc_pkg::MAC_LAT - 1);
          end
        end
        st_drain: begin
          // let the lane pipelines empty
          if (drain_cnt == '0) state <= st_send;
          else drain_cnt <= drain_cnt - 1'b1;
        end
        st_send: begin
          if (xfer) begin
            m_valid <= 1'b0;
            m_last  <= 1'b0;
            if (m_last) begin
              state <= st_idle;
              done  <= 1'b1;
            end
          end else if (!m_valid) begin
            m_valid <= 1'b1;
            m_last  <= seq.bank_last;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // result word, sign extended from the accumulator
  always_ff @(posedge clk) begin
    if (state == st_send && !m_valid) begin
      m_data <= {{(DATA_W - ACC_W){acc[seq.bank_idx][ACC_W-1]}}, acc[seq.bank_idx]};
    end
  end

endmodule

// File: logic/fc_step_cnt.sv
`timescale 1ns/1ps

module fc_step_cnt #(
  parameter int FEAT_WORDS_MAX = 64
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  fc_seq_if.cnt                                 seq,
  input  logic                                  cmd_load_feat,
  input  logic [$clog2(FEAT_WORDS_MAX+1)-1:0]   feat_words
);

  localparam int AW = $clog2(FEAT_WORDS_MAX);
  localparam int LW = $clog2(FEAT_WORDS_MAX + 1);
  localparam int SW = $clog2(fc_pkg::LANES);

  logic [LW-1:0] len;  // words per vector
  logic          word_end;
  logic          byte_end;
  logic          bank_end;

  always_ff @(posedge clk) begin
    if (!rstn) len <= LW'(1);
    else if (cmd_load_feat) len <= feat_words;
  end

  assign word_end = (LW'(seq.word_idx) == len - LW'(1));
  assign byte_end = (seq.byte_idx == SW'(fc_pkg::LANES - 1));
  assign bank_end = (seq.bank_idx == SW'(fc_pkg::LANES - 1));

  ////////////////////////////////////////
  // wrap flags widened per mode
  ////////////////////////////////////////
  always_comb begin
    seq.byte_last = byte_end;
    seq.word_last = word_end;
    seq.bank_last = bank_end;
    case (seq.mode)
      fc_pkg::compute:  seq.word_last = word_end & byte_end;  // last sample
      fc_pkg::load_wgt: seq.bank_last = bank_end & word_end;  // last weight beat
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn || seq.clear) begin
      seq.byte_idx <= '0;
      seq.word_idx <= '0;
      seq.bank_idx <= '0;
    end else if (seq.step) begin
      case (seq.mode)
        fc_pkg::load_feat: seq.word_idx <= seq.word_idx + 1'b1;
        fc_pkg::load_wgt: begin
          if (word_end) begin
            seq.word_idx <= '0;
            seq.bank_idx <= seq.bank_idx + 1'b1;
          end else begin
            seq.word_idx <= seq.word_idx + 1'b1;
          end
        end
        fc_pkg::compute: begin
          if (byte_end) begin
            seq.byte_idx <= '0;
            seq.word_idx <= seq.word_idx + 1'b1;
          end else begin
            seq.byte_idx <= seq.byte_idx + 1'b1;
          end
        end
        default: seq.bank_idx <= seq.bank_idx + 1'b1;  // send
      endcase
    end
  end

endmodule

// File: logic/fc_mac.sv
`timescale 1ns/1ps

module fc_mac (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     valid,
  input  logic                     first,
  input  logic [1:0]               byte_sel,
  input  fc_pkg::fc_word_u         feat,
  input  fc_pkg::fc_word_u         wgt,
  output logic [fc_pkg::ACC_W-1:0] acc
);

  localparam int BYTE_W = fc_pkg::BYTE_W;
  localparam int ACC_W  = fc_pkg::ACC_W;
  localparam int PROD_W = 2 * BYTE_W;
  localparam int NPAIR  = BYTE_W / 2;
  localparam int PAIR_W = BYTE_W + 2;

  // align stage
  logic       a_valid;
  logic       a_first;
  logic [1:0] a_sel;

  logic [BYTE_W-1:0]             f_byte;
  logic [BYTE_W-1:0]             w_byte;
  logic [BYTE_W-1:0]             f_mag;
  logic [BYTE_W-1:0]             w_mag;
  logic [BYTE_W-1:0][BYTE_W-1:0] pp;

  // stage 1
  logic                          s1_valid;
  logic                          s1_first;
  logic                          s1_sign;
  logic [BYTE_W-1:0][BYTE_W-1:0] s1_pp;
  logic [NPAIR-1:0][PAIR_W-1:0]  pair;

  // stage 2
  logic                         s2_valid;
  logic                         s2_first;
  logic                         s2_sign;
  logic [NPAIR-1:0][PAIR_W-1:0] s2_pair;
  logic [PROD_W-1:0]            prod_u;

  // stage 3
  logic              s3_valid;
  logic              s3_first;
  logic              s3_sign;
  logic [PROD_W-1:0] s3_prod;
  logic [PROD_W-1:0] prod_s;
  logic [ACC_W-1:0]  prod_ext;

  ////////////////////////////////////////
  // byte select and partial products
  ////////////////////////////////////////
  always_comb begin
    f_byte = feat.el[a_sel];  // buffer data lines up with a_sel
    w_byte = wgt.el[a_sel];
    f_mag  = f_byte[BYTE_W-1] ? (~f_byte + 1'b1) : f_byte;
    w_mag  = w_byte[BYTE_W-1] ? (~w_byte + 1'b1) : w_byte;
    for (int i = 0; i < BYTE_W; i++) begin
      pp[i] = w_mag[i] ? f_mag : '0;
    end
  end

  // neighbouring rows, the odd one shifted by one
  always_comb begin
    for (int j = 0; j < NPAIR; j++) begin
      pair[j] = PAIR_W'(s1_pp[2*j]) + (PAIR_W'(s1_pp[2*j+1]) << 1);
    end
  end

  always_comb begin
    prod_u = '0;
    for (int j = 0; j < NPAIR; j++) begin
      prod_u = prod_u + (PROD_W'(s2_pair[j]) << (2 * j));
    end
  end

  // sign back on, then widen for the accumulator
  assign prod_s   = s3_sign ? (~s3_prod + 1'b1) : s3_prod;
  assign prod_ext = {{(ACC_W - PROD_W){prod_s[PROD_W-1]}}, prod_s};

  ////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      a_valid  <= 1'b0;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      a_valid  <= valid;
      s1_valid <= a_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    a_first  <= first;
    a_sel    <= byte_sel;
    s1_pp    <= pp;
    s1_sign  <= f_byte[BYTE_W-1] ^ w_byte[BYTE_W-1];
    s1_first <= a_first;
    s2_pair  <= pair;
    s2_sign  <= s1_sign;
    s2_first <= s1_first;
    s3_prod  <= prod_u;  // unsigned, at most 128*128
    s3_sign  <= s2_sign;
    s3_first <= s2_first;
  end

  // wraps at ACC_W
  always_ff @(posedge clk) begin
    if (s3_valid) begin
      acc <= s3_first ? prod_ext : acc + prod_ext;
    end
  end

endmodule

// File: logic/fc_buf.sv
`timescale 1ns/1ps

module fc_buf #(
  parameter int DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  fc_pkg::fc_word_u         wdata,
  output fc_pkg::fc_word_u         rdata
);

  fc_pkg::fc_word_u mem [DEPTH];

  // single port, read returns old data on a write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];  // one cycle after addr
  end

endmodule

// File: logic/fc_seq_if.sv
`timescale 1ns/1ps

interface fc_seq_if #(
  parameter int FEAT_WORDS_MAX = 64
);

  localparam int AW = $clog2(FEAT_WORDS_MAX);
  localparam int SW = $clog2(fc_pkg::LANES);

  // driven by the FSM
  fc_pkg::fc_mode_e mode;
  logic             clear;
  logic             step;

  // driven by the counters
  logic [SW-1:0] byte_idx;
  logic [AW-1:0] word_idx;
  logic [SW-1:0] bank_idx;
  logic          word_last;
  logic          byte_last;
  logic          bank_last;

  modport ctrl (
    output mode, clear, step,
    input  byte_idx, word_idx, bank_idx, word_last, byte_last, bank_last
  );

  modport cnt (
    input  mode, clear, step,
    output byte_idx, word_idx, bank_idx, word_last, byte_last, bank_last
  );

endinterface

// File: logic/fc_pkg.sv
package fc_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int DATA_W  = 32;  // stream and buffer word
  localparam int BYTE_W  = 8;   // feature / weight element
  localparam int LANES   = 4;   // neurons, also bytes per word
  localparam int ACC_W   = 24;  // holds 256 products of 8x8
  localparam int MAC_LAT = 5;   // issue to accumulator update

  ////////////////////////////////////////
  // stream word, seen whole or as bytes
  ////////////////////////////////////////
  // elements are two's complement, el[0] is the lowest byte
  typedef union packed {
    logic [DATA_W-1:0]            raw;
    logic [LANES-1:0][BYTE_W-1:0] el;
  } fc_word_u;

  // how the step counter advances
  typedef enum logic [1:0] {
    load_feat,  // one word per step
    load_wgt,   // word wraps into next bank
    compute,    // byte wraps into next word
    send        // one bank per step
  } fc_mode_e;

endpackage
